// File: uart_frame_pkg.sv
`default_nettype none

package uart_frame_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // serial frame layout
   ////////////////////////////////////////////////////////////////////////////

   localparam int data_bits = 8;                  // payload bits per frame
   localparam int frame_bits = 1 + data_bits + 1; // start + data + stop

   // bit_duration counts clock cycles per bit
   localparam int div_w_default = 16;             // width of the bit divisor

endpackage : uart_frame_pkg

`default_nettype wire

// File: uart_bank_pkg.sv
`default_nettype none

package uart_bank_pkg;

   localparam int n_chan_default = 4;             // channels in the bank

   // index width for a channel count, never below one bit
   function automatic int chan_w(input int n);
      int w;
      w = (n > 1) ? $clog2(n) : 1;
      return w;
   endfunction

endpackage : uart_bank_pkg

`default_nettype wire

// File: uart_channel.sv
`timescale 1ns/1ns
`default_nettype none

module uart_channel #(
   parameter int div_w = uart_frame_pkg::div_w_default
) (
   input  wire                                 clk,
   input  wire                                 rst_int,
   input  wire                                 tx_en,
   input  wire                                 rx_en,
   input  wire [uart_frame_pkg::data_bits-1:0] tx_data,
   input  wire                                 data_write_en,
   input  wire                                 data_read_en,
   input  wire                                 rxd,
   input  wire                                 cts,
   input  wire [div_w-1:0]                     bit_duration,
   output logic [uart_frame_pkg::data_bits-1:0] rx_data,
   output logic                                tx_ready,
   output logic                                rx_ready,
   output wire                                 txd,
   output logic                                rts
);

   localparam int bit_cnt_w = $clog2(uart_frame_pkg::frame_bits); // holds 0..9

   typedef enum logic [1:0] {
      tx_idle,                                    // waiting for a write strobe
      tx_load,                                    // pattern load cycle
      tx_shift                                    // bits on the wire
   } tx_state_t;

   typedef enum logic [2:0] {
      rx_sync,                                    // wait for a high line
      rx_high,                                    // line must stay high one bit
      rx_wait,                                    // idle line, look for start
      rx_start,                                   // confirm start at mid bit
      rx_bits                                     // sample data then stop
   } rx_state_t;

   logic [1:0]                                cts_q;  // cts synchroniser
   tx_state_t                                 tx_st;
   logic [uart_frame_pkg::frame_bits-1:0]     tx_pattern;
   logic [bit_cnt_w-1:0]                      tx_bitcnt;
   logic [div_w-1:0]                          tx_cyclecnt;
   rx_state_t                                 rx_st;
   logic [bit_cnt_w-1:0]                      rx_bitcnt;
   logic [div_w-1:0]                          rx_cyclecnt;
   logic [uart_frame_pkg::data_bits-1:0]      rx_pattern;
   logic                                      rx_tick;  // sample point in rx_bits

   ////////////////////////////////////////////////////////////////////////////
   // transmit
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         cts_q <= '0;
      end else begin
         cts_q <= {cts_q[0], cts};                // two flops so cts is seen 2 cycles late
      end
   end

   assign txd = tx_pattern[0];                    // lsb goes out first

   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         tx_st       <= tx_idle;
         tx_ready    <= 1'b0;
         tx_pattern  <= '1;                       // line idles high
         tx_bitcnt   <= '0;
         tx_cyclecnt <= '0;
      end else if (tx_en && cts_q[1]) begin
         case (tx_st)
            tx_idle: begin
               tx_ready    <= ~data_write_en;     // drops the cycle after the strobe
               tx_bitcnt   <= '0;
               tx_cyclecnt <= div_w'(1);
               tx_pattern  <= '1;
               if (data_write_en) begin
                  tx_st <= tx_load;
               end
            end
            tx_load: begin
               tx_pattern <= {1'b1, tx_data, 1'b0}; // stop, data, start
               tx_st      <= tx_shift;
            end
            tx_shift: begin
               if (tx_cyclecnt == bit_duration) begin
                  if (tx_bitcnt == bit_cnt_w'(uart_frame_pkg::frame_bits - 1)) begin
                     tx_st <= tx_idle;            // stop bit done
                  end else begin
                     tx_pattern  <= {1'b1, tx_pattern[uart_frame_pkg::frame_bits-1:1]};
                     tx_bitcnt   <= tx_bitcnt + 1'b1;
                     tx_cyclecnt <= div_w'(1);
                  end
               end else begin
                  tx_cyclecnt <= tx_cyclecnt + 1'b1;
               end
            end
            default: tx_st <= tx_idle;
         endcase
      end else begin
         // disabled or no clear to send so any frame is aborted
         tx_st       <= tx_idle;
         tx_ready    <= 1'b0;
         tx_pattern  <= '1;
         tx_bitcnt   <= '0;
         tx_cyclecnt <= '0;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // receive
   ////////////////////////////////////////////////////////////////////////////

   assign rx_tick = rx_en && (rx_st == rx_bits) && (rx_cyclecnt == bit_duration);

   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         rx_st       <= rx_sync;
         rx_cyclecnt <= div_w'(1);
         rx_bitcnt   <= '0;
         rx_ready    <= 1'b0;
         rts         <= 1'b0;
      end else if (rx_en) begin
         case (rx_st)
            rx_sync: begin
               rts         <= 1'b1;               // ready to receive
               rx_ready    <= 1'b0;
               rx_cyclecnt <= div_w'(1);
               rx_bitcnt   <= '0;
               if (rxd) begin
                  rx_st <= rx_high;
               end
            end
            rx_high: begin
               rx_cyclecnt <= rx_cyclecnt + 1'b1;
               if (rx_cyclecnt == bit_duration) begin
                  rx_st <= rxd ? rx_wait : rx_sync; // low too early so resync
               end
            end
            rx_wait: begin
               rx_cyclecnt <= div_w'(1);
               if (!rxd) begin
                  rx_st <= rx_start;              // falling edge of start bit
               end
            end
            rx_start: begin
               rx_cyclecnt <= rx_cyclecnt + 1'b1;
               if (rx_cyclecnt == (bit_duration >> 1)) begin
                  if (rxd) begin
                     rx_st <= rx_sync;            // glitch not a start bit
                  end else begin
                     rx_cyclecnt <= div_w'(1);    // now aligned to mid bit
                     rx_st       <= rx_bits;
                  end
               end
            end
            rx_bits: begin
               rx_cyclecnt <= rx_cyclecnt + 1'b1;
               if (rx_tick) begin
                  rx_cyclecnt <= div_w'(1);
                  if (rx_bitcnt == bit_cnt_w'(uart_frame_pkg::data_bits)) begin
                     rx_ready  <= 1'b1;           // stop bit reached
                     rx_bitcnt <= '0;
                     rx_st     <= rx_wait;
                  end else begin
                     rx_bitcnt <= rx_bitcnt + 1'b1;
                  end
               end
            end
            default: rx_st <= rx_sync;
         endcase
         if (data_read_en) begin
            rx_ready <= 1'b0;                     // host took the byte
         end
      end else begin
         rx_st       <= rx_sync;
         rx_cyclecnt <= div_w'(1);
         rx_bitcnt   <= '0;
         rx_ready    <= 1'b0;
         rts         <= 1'b0;
      end
   end

   // shift register and output byte
   always_ff @(posedge clk) begin
      if (rx_tick) begin
         if (rx_bitcnt == bit_cnt_w'(uart_frame_pkg::data_bits)) begin
            rx_data <= rx_pattern;                // stop sample not shifted in
         end else begin
            rx_pattern <= {rxd, rx_pattern[uart_frame_pkg::data_bits-1:1]};
         end
      end
   end

endmodule : uart_channel

`default_nettype wire

// File: uart_tx_dispatch.sv
`timescale 1ns/1ns
`default_nettype none

module uart_tx_dispatch #(
   parameter int n_chan = uart_bank_pkg::n_chan_default
) (
   input  wire                                          clk,
   input  wire                                          rst_int,
   input  wire                                          wr_en,
   input  wire [uart_bank_pkg::chan_w(n_chan)-1:0]      wr_chan,
   input  wire [uart_frame_pkg::data_bits-1:0]          wr_data,
   input  wire [n_chan-1:0]                             tx_ready,
   output logic [n_chan-1:0]                            wr_full,
   output wire [n_chan-1:0]                             data_write_en,
   output wire [n_chan*uart_frame_pkg::data_bits-1:0]   tx_data
);

   localparam int cw = uart_bank_pkg::chan_w(n_chan);
   localparam int dw = uart_frame_pkg::data_bits;

   logic [dw-1:0]     slot_q [n_chan];            // one byte per channel
   logic [n_chan-1:0] take;                       // host write lands in slot

   for (genvar i = 0; i < n_chan; i++) begin : g_slot
      assign take[i] = wr_en && !wr_full[i] && (wr_chan == cw'(i)); // full slot drops it
      assign tx_data[i*dw +: dw] = slot_q[i];
   end

   // hand the byte over as soon as the channel is idle
   assign data_write_en = wr_full & tx_ready;

   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         wr_full <= '0;
      end else begin
         for (int i = 0; i < n_chan; i++) begin
            if (take[i]) begin
               wr_full[i] <= 1'b1;                // full on the next edge
            end else if (data_write_en[i]) begin
               wr_full[i] <= 1'b0;                // channel took it
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < n_chan; i++) begin
         if (take[i]) begin
            slot_q[i] <= wr_data;
         end
      end
   end

endmodule : uart_tx_dispatch

`default_nettype wire

// File: uart_rx_collect.sv
`timescale 1ns/1ns
`default_nettype none

module uart_rx_collect #(
   parameter int n_chan = uart_bank_pkg::n_chan_default
) (
   input  wire                                          clk,
   input  wire                                          rst_int,
   input  wire [n_chan-1:0]                             rx_ready,
   input  wire [n_chan*uart_frame_pkg::data_bits-1:0]   rx_data,
   output logic [n_chan-1:0]                            data_read_en,
   output logic                                         rd_valid,
   output logic [uart_bank_pkg::chan_w(n_chan)-1:0]     rd_chan,
   output logic [uart_frame_pkg::data_bits-1:0]         rd_data
);

   localparam int cw = uart_bank_pkg::chan_w(n_chan);
   localparam int dw = uart_frame_pkg::data_bits;

   logic [cw-1:0]     ptr_q;                      // first channel to look at
   logic [n_chan-1:0] req;
   logic [n_chan-1:0] gnt_oh;
   logic [cw-1:0]     gnt_idx;
   logic              gnt_any;

   // rx_ready still high during the read pulse so mask that channel
   assign req = rx_ready & ~data_read_en;

   always_comb begin : pick
      int idx;
      gnt_any = 1'b0;
      gnt_idx = '0;
      gnt_oh  = '0;
      for (int k = 0; k < n_chan; k++) begin
         idx = (int'(ptr_q) + k) % n_chan;        // rotate from the pointer
         if (!gnt_any && req[idx]) begin
            gnt_any     = 1'b1;
            gnt_idx     = cw'(idx);
            gnt_oh[idx] = 1'b1;
         end
      end
   end

   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         ptr_q        <= '0;
         rd_valid     <= 1'b0;
         data_read_en <= '0;
      end else begin
         rd_valid     <= gnt_any;                 // one cycle after the grant
         data_read_en <= gnt_oh;
         if (gnt_any) begin
            ptr_q <= (int'(gnt_idx) == n_chan - 1) ? '0 : gnt_idx + 1'b1; // past last grant
         end
      end
   end

   // tag and byte travel with rd_valid
   always_ff @(posedge clk) begin
      if (gnt_any) begin
         rd_chan <= gnt_idx;
         rd_data <= rx_data[gnt_idx*dw +: dw];
      end
   end

endmodule : uart_rx_collect

`default_nettype wire

// File: uart_bank.sv
`timescale 1ns/1ns
`default_nettype none

module uart_bank #(
   parameter int n_chan = uart_bank_pkg::n_chan_default,
   parameter int div_w  = uart_frame_pkg::div_w_default
) (
   input  wire                                      clk,
   input  wire                                      rst_int,
   input  wire                                      tx_en,
   input  wire                                      rx_en,
   input  wire [div_w-1:0]                          bit_duration, // at least 4
   input  wire                                      wr_en,
   input  wire [uart_bank_pkg::chan_w(n_chan)-1:0]  wr_chan,
   input  wire [uart_frame_pkg::data_bits-1:0]      wr_data,
   input  wire [n_chan-1:0]                         rxd,
   input  wire [n_chan-1:0]                         cts,
   output wire [n_chan-1:0]                         wr_full,
   output wire                                      rd_valid,
   output wire [uart_bank_pkg::chan_w(n_chan)-1:0]  rd_chan,
   output wire [uart_frame_pkg::data_bits-1:0]      rd_data,
   output wire [n_chan-1:0]                         txd,
   output wire [n_chan-1:0]                         rts
);

   localparam int dw = uart_frame_pkg::data_bits;

   wire [n_chan-1:0]    tx_ready;                 // per channel levels and strobes
   wire [n_chan-1:0]    rx_ready;
   wire [n_chan-1:0]    data_write_en;
   wire [n_chan-1:0]    data_read_en;
   wire [n_chan*dw-1:0] tx_data;                  // channel i at bits i*8
   wire [n_chan*dw-1:0] rx_data;

   ////////////////////////////////////////////////////////////////////////////
   // host write side
   ////////////////////////////////////////////////////////////////////////////

   uart_tx_dispatch #(
      .n_chan        (n_chan)
   ) u_dispatch (
      .clk           (clk),
      .rst_int       (rst_int),
      .wr_en         (wr_en),
      .wr_chan       (wr_chan),
      .wr_data       (wr_data),
      .tx_ready      (tx_ready),
      .wr_full       (wr_full),
      .data_write_en (data_write_en),
      .tx_data       (tx_data)
   );

   ////////////////////////////////////////////////////////////////////////////
   // channels
   ////////////////////////////////////////////////////////////////////////////

   for (genvar i = 0; i < n_chan; i++) begin : g_chan
      uart_channel #(
         .div_w         (div_w)
      ) u_chan (
         .clk           (clk),
         .rst_int       (rst_int),
         .tx_en         (tx_en),
         .rx_en         (rx_en),
         .tx_data       (tx_data[i*dw +: dw]),
         .data_write_en (data_write_en[i]),
         .data_read_en  (data_read_en[i]),
         .rxd           (rxd[i]),
         .cts           (cts[i]),
         .bit_duration  (bit_duration),
         .rx_data       (rx_data[i*dw +: dw]),
         .tx_ready      (tx_ready[i]),
         .rx_ready      (rx_ready[i]),
         .txd           (txd[i]),
         .rts           (rts[i])
      );
   end

   ////////////////////////////////////////////////////////////////////////////
   // host read side
   ////////////////////////////////////////////////////////////////////////////

   uart_rx_collect #(
      .n_chan       (n_chan)
   ) u_collect (
      .clk          (clk),
      .rst_int      (rst_int),
      .rx_ready     (rx_ready),
      .rx_data      (rx_data),
      .data_read_en (data_read_en),
      .rd_valid     (rd_valid),
      .rd_chan      (rd_chan),
      .rd_data      (rd_data)
   );

endmodule : uart_bank

`default_nettype wire

// File: uart_bank_tb.sv
`timescale 1ns/1ns
`default_nettype none

module uart_bank_tb;

   localparam int n_chan    = uart_bank_pkg::n_chan_default;
   localparam int cw        = uart_bank_pkg::chan_w(n_chan);
   localparam int dw        = uart_frame_pkg::data_bits;
   localparam int fb        = uart_frame_pkg::frame_bits;
   localparam int div_w     = uart_frame_pkg::div_w_default;
   localparam int bit_dur   = 8;                  // clocks per serial bit
   localparam int clk_ns    = 4;
   localparam int all_ones  = (1 << n_chan) - 1;
   localparam int frame_cyc = (fb + 2) * bit_dur; // tx frame plus rx lag
   localparam int n_frames  = 12;                 // frames sent over all tests
   localparam int watchdog_ns = 4 * n_frames * frame_cyc * clk_ns;

   logic              clk = 1'b0;
   logic              rst_int = 1'b1;
   logic              tx_en;
   logic              rx_en;
   logic [div_w-1:0]  bit_duration;
   logic              wr_en;
   logic [cw-1:0]     wr_chan;
   logic [dw-1:0]     wr_data;
   logic [n_chan-1:0] cts;
   wire  [n_chan-1:0] wr_full;
   wire               rd_valid;
   wire  [cw-1:0]     rd_chan;
   wire  [dw-1:0]     rd_data;
   wire  [n_chan-1:0] txd;                        // looped back into rxd
   wire  [n_chan-1:0] rts;

   int                errors = 0;
   int                read_errs = 0;
   int                flow_errs = 0;
   int                checks = 0;
   int                tests = 0;
   int                test_err0 = 0;
   string             cur_test = "none";
   int                rd_chan_q [$];              // reads seen by the monitor
   int                rd_data_q [$];
   logic [n_chan-1:0] expect_rd = '0;             // channels allowed to return a byte

   always #(clk_ns / 2) clk = ~clk;

   uart_bank #(
      .n_chan       (n_chan),
      .div_w        (div_w)
   ) UUT (
      .clk          (clk),
      .rst_int      (rst_int),
      .tx_en        (tx_en),
      .rx_en        (rx_en),
      .bit_duration (bit_duration),
      .wr_en        (wr_en),
      .wr_chan      (wr_chan),
      .wr_data      (wr_data),
      .rxd          (txd),
      .cts          (cts),
      .wr_full      (wr_full),
      .rd_valid     (rd_valid),
      .rd_chan      (rd_chan),
      .rd_data      (rd_data),
      .txd          (txd),
      .rts          (rts)
   );

   ////////////////////////////////////////////////////////////////////////////
   // monitor and concurrent checks
   ////////////////////////////////////////////////////////////////////////////

   always @(posedge clk) begin
      if (!rst_int && rd_valid) begin
         rd_chan_q.push_back(int'(rd_chan));      // pre-edge values
         rd_data_q.push_back(int'(rd_data));
      end
   end

   // a read only for a channel with a byte in flight
   assert property (@(posedge clk) disable iff (rst_int) rd_valid |-> expect_rd[rd_chan])
      else begin
         read_errs++;
         $display("error in %s: read pulse on channel %0d with nothing in flight",
                  cur_test, $sampled(rd_chan));
      end

   // line must idle once cts has been low for 4 samples
   assert property (@(posedge clk) disable iff (rst_int)
      (~cts & ~$past(cts) & ~$past(cts, 2) & ~$past(cts, 3) & ~txd) == '0)
      else begin
         flow_errs++;
         $display("error in %s: txd left idle while cts was low", cur_test);
      end

   ////////////////////////////////////////////////////////////////////////////
   // helpers
   ////////////////////////////////////////////////////////////////////////////

   function automatic int total_errors();
      return errors + read_errs + flow_errs;
   endfunction

   task automatic check_value(input string what, input int exp, input int act);
      checks++;
      assert (act == exp) else begin
         errors++;
         $display("[FAIL] %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
      end
   endtask

   task automatic report_error(input string msg);
      errors++;
      $display("error in %s: %s", cur_test, msg);
   endtask

   task automatic start_test(input string name);
      cur_test  = name;
      test_err0 = total_errors();
   endtask

   task automatic end_test();
      int n;
      n = total_errors() - test_err0;
      tests++;
      if (n == 0) begin
         $display("test %s: ok", cur_test);
      end else begin
         $display("test %s: %0d error(s)", cur_test, n);
      end
   endtask

   // one-cycle write strobe that returns on the edge taking it
   task automatic write_byte(input int ch, input logic [dw-1:0] data);
      @(posedge clk);
      wr_en   <= 1'b1;
      wr_chan <= cw'(ch);
      wr_data <= data;
      @(posedge clk);
      wr_en   <= 1'b0;
   endtask

   task automatic wait_read(output int ch, output int data);
      int n;
      n = 0;
      ch = -1;
      data = -1;
      @(negedge clk);
      while (rd_chan_q.size() == 0 && n < 2 * frame_cyc) begin
         @(negedge clk);
         n++;
      end
      if (rd_chan_q.size() == 0) begin
         report_error("no read pulse before the timeout");
      end else begin
         ch   = rd_chan_q.pop_front();
         data = rd_data_q.pop_front();
      end
   endtask

   task automatic wait_slot_empty(input int ch);
      int n;
      n = 0;
      @(negedge clk);
      while (wr_full[ch] && n < frame_cyc) begin
         @(negedge clk);
         n++;
      end
      if (wr_full[ch]) begin
         report_error($sformatf("slot of channel %0d never emptied", ch));
      end
   endtask

   // every clock of the frame against the expected line level
   task automatic check_frame(input int ch, input logic [dw-1:0] data);
      int   n;
      logic exp_bit;
      n = 0;
      @(negedge clk);
      while (txd[ch] && n < frame_cyc) begin
         @(negedge clk);
         n++;
      end
      if (txd[ch]) begin
         report_error($sformatf("no start bit on channel %0d", ch));
      end else begin
         for (int b = 0; b < fb; b++) begin
            if (b == 0) begin
               exp_bit = 1'b0;                    // start bit
            end else if (b <= dw) begin
               exp_bit = data[b-1];               // data lsb first
            end else begin
               exp_bit = 1'b1;                    // stop bit
            end
            for (int c = 0; c < bit_dur; c++) begin
               if (b != 0 || c != 0) begin
                  @(negedge clk);
               end
               check_value($sformatf("txd ch%0d bit %0d", ch, b),
                           int'(exp_bit), int'(txd[ch]));
            end
         end
      end
   endtask

   task automatic idle_check(input int cycles);
      repeat (cycles) @(negedge clk);
      check_value("reads left over", 0, rd_chan_q.size());
      rd_chan_q.delete();
      rd_data_q.delete();
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // tests
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      int            ch;
      int            data;
      int            n;
      int            seen [n_chan];
      logic [dw-1:0] bytes_w [n_chan];
      void'($urandom(32'h2e44_cc71));
      tx_en        = 1'b1;
      rx_en        = 1'b1;
      bit_duration = div_w'(bit_dur);
      wr_en        = 1'b0;
      wr_chan      = '0;
      wr_data      = '0;
      cts          = '1;

      start_test("reset_state");
      repeat (2) @(posedge clk);
      @(negedge clk);
      check_value("txd in reset", all_ones, int'(txd));
      check_value("rts in reset", 0, int'(rts));
      check_value("wr_full in reset", 0, int'(wr_full));
      check_value("rd_valid in reset", 0, int'(rd_valid));
      @(posedge clk);
      rst_int <= 1'b0;                            // third edge in reset
      n = 0;
      @(negedge clk);
      while (rts != '1 && n < 4) begin
         @(negedge clk);
         n++;
      end
      check_value("rts after reset", all_ones, int'(rts));
      check_value("txd after reset", all_ones, int'(txd));
      check_value("wr_full after reset", 0, int'(wr_full));
      check_value("rd_valid after reset", 0, int'(rd_valid));
      repeat (2 * bit_dur) @(posedge clk);        // rx needs an idle bit first
      end_test();

      start_test("loopback_frame");
      for (int k = 0; k < n_chan; k++) begin
         bytes_w[k]   = dw'($urandom);
         expect_rd[k] = 1'b1;
         fork
            write_byte(k, bytes_w[k]);
            check_frame(k, bytes_w[k]);
         join
         wait_read(ch, data);
         check_value("rd_chan", k, ch);
         check_value("rd_data", int'(bytes_w[k]), data);
         expect_rd[k] = 1'b0;
      end
      idle_check(frame_cyc);
      end_test();

      start_test("holding_slot");
      for (int k = 0; k < 3; k++) begin
         bytes_w[k] = dw'($urandom);
      end
      expect_rd[1] = 1'b1;
      write_byte(1, bytes_w[0]);
      @(negedge clk);
      check_value("wr_full after first write", 1, int'(wr_full[1]));
      wait_slot_empty(1);                         // first byte now in the channel
      write_byte(1, bytes_w[1]);
      @(negedge clk);
      check_value("wr_full after second write", 1, int'(wr_full[1]));
      write_byte(1, bytes_w[2]);                  // slot full so dropped
      repeat (bit_dur) @(negedge clk);
      check_value("wr_full during frame", 1, int'(wr_full[1]));
      for (int k = 0; k < 2; k++) begin
         wait_read(ch, data);
         check_value("rd_chan", 1, ch);
         check_value($sformatf("rd_data %0d", k), int'(bytes_w[k]), data);
      end
      idle_check(frame_cyc);
      check_value("wr_full at end", 0, int'(wr_full[1]));
      expect_rd[1] = 1'b0;
      end_test();

      start_test("flow_control");
      @(posedge clk);
      cts[2] <= 1'b0;
      repeat (4) @(posedge clk);
      bytes_w[0]   = dw'($urandom);
      expect_rd[2] = 1'b1;
      write_byte(2, bytes_w[0]);
      repeat (3 * bit_dur) begin
         @(negedge clk);
         check_value("txd with cts low", 1, int'(txd[2]));
         check_value("wr_full with cts low", 1, int'(wr_full[2]));
      end
      @(posedge clk);
      cts[2] <= 1'b1;                             // releases the held byte
      check_frame(2, bytes_w[0]);
      wait_read(ch, data);
      check_value("rd_chan", 2, ch);
      check_value("rd_data", int'(bytes_w[0]), data);
      expect_rd[2] = 1'b0;
      @(posedge clk);
      rx_en <= 1'b0;
      bytes_w[1] = dw'($urandom);
      write_byte(3, bytes_w[1]);                  // frame goes out but nothing is read
      check_frame(3, bytes_w[1]);
      repeat (2 * bit_dur) @(negedge clk);
      check_value("reads with rx_en low", 0, rd_chan_q.size());
      check_value("rts with rx_en low", 0, int'(rts));
      @(posedge clk);
      rx_en <= 1'b1;
      repeat (2 * bit_dur) @(posedge clk);        // resync on the idle line
      end_test();

      start_test("concurrent");
      for (int k = 0; k < n_chan; k++) begin
         bytes_w[k] = dw'($urandom);
         seen[k]    = 0;
      end
      expect_rd = '1;
      @(posedge clk);
      cts <= '0;                                  // hold all slots
      repeat (4) @(posedge clk);
      for (int k = 0; k < n_chan; k++) begin
         write_byte(k, bytes_w[k]);
      end
      @(negedge clk);
      check_value("all slots held", all_ones, int'(wr_full));
      @(posedge clk);
      cts <= '1;                                  // all frames start together
      for (int k = 0; k < n_chan; k++) begin
         wait_read(ch, data);
         if (ch >= 0) begin
            seen[ch]++;
            check_value($sformatf("rd_data ch%0d", ch), int'(bytes_w[ch]), data);
         end
      end
      for (int k = 0; k < n_chan; k++) begin
         check_value($sformatf("reads on ch%0d", k), 1, seen[k]);
      end
      idle_check(frame_cyc);
      expect_rd = '0;
      end_test();

      $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, total_errors());
      if (total_errors() == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

   // four times the frame time of every test
   initial begin
      #(watchdog_ns);
      $display("watchdog expired in test %s after %0d ns", cur_test, watchdog_ns);
      $display("Testbench failed");
      $finish;
   end

endmodule : uart_bank_tb

`default_nettype wire

// File: uart_bank.f
uart_frame_pkg.sv
uart_bank_pkg.sv
uart_channel.sv
uart_tx_dispatch.sv
uart_rx_collect.sv
uart_bank.sv
uart_bank_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ns -j 0
TOP       = uart_bank_tb
FILELIST  = uart_bank.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf $(OBJ_DIR)
